// File: src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define LSU_XLEN    64
`define LSU_BE_W    8

// scoreboard tag width
`define LSU_TID_W   3

// ------------------------------------------------------------
// virtual address space
// ------------------------------------------------------------
// bits XLEN-1 down to VA_BITS-1 must be copies of one another
`define LSU_VA_BITS 39

`endif

// File: src/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    // load/store operator as sent by issue
    typedef enum logic [3:0] {
        LD, LW, LWU, LH, LHU, LB, LBU,
        SD, SW, SH, SB
    } lsu_op_e;

    // RISC-V exception cause codes raised here
    typedef enum logic [5:0] {
        LD_ADDR_MISALIGNED = 6'd4,
        ST_ADDR_MISALIGNED = 6'd6,
        LOAD_PAGE_FAULT    = 6'd13,
        STORE_PAGE_FAULT   = 6'd15
    } lsu_cause_e;

    typedef struct packed {
        logic                 valid;
        lsu_cause_e           cause;
        logic [`LSU_XLEN-1:0] tval;   // faulting address
    } lsu_ex_t;

    // one load or store on its way to memory
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  vaddr;
        logic [`LSU_XLEN-1:0]  wdata;
        logic [`LSU_BE_W-1:0]  be;
        logic                  is_store;
        lsu_op_e               op;
        logic [`LSU_TID_W-1:0] trans_id;
        lsu_ex_t               ex;
    } lsu_req_t;

    // ------------------------------------------------------------
    // data memory port, req/gnt/rvalid
    // ------------------------------------------------------------
    typedef struct packed {
        logic                 req;
        logic                 we;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_BE_W-1:0] be;
        logic [`LSU_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 gnt;
        logic                 rvalid;
        logic [`LSU_XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

// File: src/lsu_addr_gen.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_addr_gen
    import lsu_pkg::*;
(
    input  logic                  valid_i,
    input  logic                  fu_store_i,
    input  lsu_op_e               operator_i,
    input  logic [`LSU_XLEN-1:0]  operand_a_i,
    input  logic [`LSU_XLEN-1:0]  operand_b_i,
    input  logic [`LSU_XLEN-1:0]  imm_i,
    input  logic [`LSU_TID_W-1:0] trans_id_i,
    output lsu_req_t              req_o
);

    logic [`LSU_XLEN-1:0] vaddr;
    logic [2:0]           offset;
    logic [1:0]           size_log2;
    logic [`LSU_BE_W-1:0] width_mask;
    logic                 misaligned;
    logic                 canonical;

    assign vaddr  = operand_a_i + imm_i;
    assign offset = vaddr[2:0];

    // ------------------------------------------------------------
    // access size and byte enables
    // ------------------------------------------------------------
    always_comb begin : size_decode
        unique case (operator_i)
            LD, SD:       size_log2 = 2'd3;
            LW, LWU, SW:  size_log2 = 2'd2;
            LH, LHU, SH:  size_log2 = 2'd1;
            default:      size_log2 = 2'd0;
        endcase
    end

    always_comb begin : mask_decode
        unique case (size_log2)
            2'd3:    width_mask = 8'hff;
            2'd2:    width_mask = 8'h0f;
            2'd1:    width_mask = 8'h03;
            default: width_mask = 8'h01;
        endcase
    end

    // low address bits below the access size must be zero
    always_comb begin : align_check
        unique case (size_log2)
            2'd3:    misaligned = |offset;
            2'd2:    misaligned = |offset[1:0];
            2'd1:    misaligned = offset[0];
            default: misaligned = 1'b0;
        endcase
    end

    // upper bits all ones or all zeros
    assign canonical = (&vaddr[`LSU_XLEN-1:`LSU_VA_BITS-1]) ||
                       !(|vaddr[`LSU_XLEN-1:`LSU_VA_BITS-1]);

    // ------------------------------------------------------------
    // request assembly
    // ------------------------------------------------------------
    always_comb begin : build_req
        req_o.valid    = valid_i;
        req_o.vaddr    = vaddr;
        req_o.wdata    = operand_b_i << {offset, 3'b000};
        req_o.be       = width_mask << offset;
        req_o.is_store = fu_store_i;
        req_o.op       = operator_i;
        req_o.trans_id = trans_id_i;

        req_o.ex.valid = misaligned || !canonical;
        req_o.ex.cause = fu_store_i ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
        req_o.ex.tval  = vaddr;
        // page fault wins over misalignment
        if (!canonical) begin
            req_o.ex.cause = fu_store_i ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        end
    end

endmodule

// File: src/lsu_load_align.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_load_align
    import lsu_pkg::*;
(
    input  lsu_op_e              op_i,
    input  logic [2:0]           offset_i,
    input  logic [`LSU_XLEN-1:0] rdata_i,
    output logic [`LSU_XLEN-1:0] data_o
);

    logic [`LSU_XLEN-1:0] shifted;

    // addressed byte moves down to lane 0
    assign shifted = rdata_i >> {offset_i, 3'b000};

    always_comb begin : extend
        unique case (op_i)
            LB:      data_o = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     data_o = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            LH:      data_o = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     data_o = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            LW:      data_o = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
            LWU:     data_o = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
            // full doubleword
            default: data_o = shifted;
        endcase
    end

endmodule

// File: src/lsu_issue_buffer.sv
`timescale 1ns/1ps

module lsu_issue_buffer
    import lsu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  lsu_req_t req_i,
    input  logic     pop_i,
    output lsu_req_t head_o,
    output logic     ready_o
);

    lsu_req_t [1:0] mem_q;
    logic           rd_ptr_q;
    logic           wr_ptr_q;
    logic [1:0]     cnt_q;

    logic empty;
    logic bypass;
    logic push;
    logic pop;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // empty buffer hands the incoming request straight through
    assign head_o = empty ? req_i : mem_q[rd_ptr_q];

    assign bypass = empty && pop_i;
    assign push   = req_i.valid && ready_o && !bypass;
    assign pop    = pop_i && !empty;

    // ------------------------------------------------------------
    // pointers and fill level
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            unique case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 2'd1;
                2'b01:   cnt_q <= cnt_q - 2'd1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    // controller only takes a valid head
    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> head_o.valid)
        else $error("pop with no valid request at the head");

endmodule

// File: src/lsu_mem_ctrl.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_mem_ctrl
    import lsu_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  lsu_req_t              head_i,
    output logic                  pop_o,
    output mem_req_t              mem_req_o,
    input  mem_rsp_t              mem_rsp_i,
    output logic                  valid_o,
    output logic [`LSU_TID_W-1:0] trans_id_o,
    output logic [`LSU_XLEN-1:0]  result_o,
    output lsu_ex_t               ex_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT_RD
    } state_e;

    state_e state_q, state_d;

    mem_req_t              mreq_q;
    logic [`LSU_TID_W-1:0] tid_q;
    lsu_op_e               ld_op_q;
    logic [2:0]            ld_off_q;
    logic [`LSU_XLEN-1:0]  ld_data;

    logic take;
    logic fault_done;
    logic store_done;
    logic load_done;

    assign take       = (state_q == S_IDLE) && head_i.valid;
    assign pop_o      = take;
    assign fault_done = take && head_i.ex.valid;
    assign store_done = (state_q == S_REQ) && mem_rsp_i.gnt && mreq_q.we;
    assign load_done  = (state_q == S_WAIT_RD) && mem_rsp_i.rvalid;

    // ------------------------------------------------------------
    // access FSM
    // ------------------------------------------------------------
    always_comb begin : next_state
        state_d = state_q;
        unique case (state_q)
            S_IDLE: begin
                // faults retire here and never touch memory
                if (take && !head_i.ex.valid) begin
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                if (mem_rsp_i.gnt) begin
                    state_d = mreq_q.we ? S_IDLE : S_WAIT_RD;
                end
            end
            S_WAIT_RD: begin
                if (mem_rsp_i.rvalid) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request payload and load context, held for the whole access
    always_ff @(posedge clk_i) begin
        if (take) begin
            mreq_q.req   <= 1'b1;
            mreq_q.we    <= head_i.is_store;
            mreq_q.addr  <= head_i.vaddr;
            mreq_q.be    <= head_i.be;
            mreq_q.wdata <= head_i.wdata;
            tid_q        <= head_i.trans_id;
            ld_op_q      <= head_i.op;
            ld_off_q     <= head_i.vaddr[2:0];
        end
    end

    always_comb begin : drive_port
        mem_req_o     = mreq_q;
        mem_req_o.req = (state_q == S_REQ);
    end

    lsu_load_align i_load_align (
        .op_i     ( ld_op_q             ),
        .offset_i ( ld_off_q            ),
        .rdata_i  ( mem_rsp_i.rdata     ),
        .data_o   ( ld_data             )
    );

    // ------------------------------------------------------------
    // result register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o    <= 1'b0;
            trans_id_o <= '0;
            result_o   <= '0;
            ex_o       <= '0;
        end else begin
            valid_o <= fault_done || store_done || load_done;
            if (fault_done) begin
                trans_id_o <= head_i.trans_id;
                result_o   <= '0;
                ex_o       <= head_i.ex;
            end else if (store_done) begin
                trans_id_o <= tid_q;
                result_o   <= '0;
                ex_o       <= '0;
            end else if (load_done) begin
                trans_id_o <= tid_q;
                result_o   <= ld_data;
                ex_o       <= '0;
            end
        end
    end

    // a stalled request must not change under the memory
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.req && !mem_rsp_i.gnt) |=> $stable(mem_req_o))
        else $error("memory request changed while waiting for grant");

endmodule

// File: src/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // issue side
    input  logic                  lsu_valid_i,
    input  logic                  fu_store_i,
    input  lsu_op_e               operator_i,
    input  logic [`LSU_XLEN-1:0]  operand_a_i,
    input  logic [`LSU_XLEN-1:0]  operand_b_i,
    input  logic [`LSU_XLEN-1:0]  imm_i,
    input  logic [`LSU_TID_W-1:0] trans_id_i,
    output logic                  lsu_ready_o,
    // data memory
    output mem_req_t              mem_req_o,
    input  mem_rsp_t              mem_rsp_i,
    // writeback
    output logic                  lsu_valid_o,
    output logic [`LSU_TID_W-1:0] lsu_trans_id_o,
    output logic [`LSU_XLEN-1:0]  lsu_result_o,
    output lsu_ex_t               lsu_ex_o
);

    lsu_req_t new_req;
    lsu_req_t head;
    logic     pop;

    lsu_addr_gen i_addr_gen (
        .valid_i     ( lsu_valid_i ),
        .fu_store_i  ( fu_store_i  ),
        .operator_i  ( operator_i  ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .imm_i       ( imm_i       ),
        .trans_id_i  ( trans_id_i  ),
        .req_o       ( new_req     )
    );

    lsu_issue_buffer i_issue_buffer (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .req_i   ( new_req     ),
        .pop_i   ( pop         ),
        .head_o  ( head        ),
        .ready_o ( lsu_ready_o )
    );

    lsu_mem_ctrl i_mem_ctrl (
        .clk_i      ( clk_i          ),
        .rst_ni     ( rst_ni         ),
        .head_i     ( head           ),
        .pop_o      ( pop            ),
        .mem_req_o  ( mem_req_o      ),
        .mem_rsp_i  ( mem_rsp_i      ),
        .valid_o    ( lsu_valid_o    ),
        .trans_id_o ( lsu_trans_id_o ),
        .result_o   ( lsu_result_o   ),
        .ex_o       ( lsu_ex_o       )
    );

endmodule

// File: verification/tb_lsu_mem.sv
`timescale 1ns/1ps

module tb_lsu_mem
    import lsu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  mem_req_t mem_req_i,
    output mem_rsp_t mem_rsp_o
);

    logic [63:0] mem_q [0:63];
    logic [1:0]  delay_q;
    logic [1:0]  wait_q;
    logic        rvalid_q;
    logic [63:0] rdata_q;
    logic        gnt;
    logic [5:0]  idx;
    logic [31:0] rnd;
    integer      seed;
    integer      i;
    integer      k;

    // doubleword index from address bits 8 down to 3
    assign idx = mem_req_i.addr[8:3];
    assign gnt = mem_req_i.req && (wait_q == delay_q);

    assign mem_rsp_o.gnt    = gnt;
    assign mem_rsp_o.rvalid = rvalid_q;
    assign mem_rsp_o.rdata  = rdata_q;

    initial begin
        seed = 32'h5b3d_b403;
        for (i = 0; i < 64; i++) begin
            mem_q[i] = {i * 32'h0101_0101, ~i};
        end
    end

    // grant after 0 to 3 cycles, read data one cycle after grant
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            delay_q  <= 2'd0;
            wait_q   <= 2'd0;
            rvalid_q <= 1'b0;
            rdata_q  <= 64'h0;
        end else begin
            rvalid_q <= gnt && !mem_req_i.we;
            if (gnt) begin
                rnd = $random(seed);
                delay_q <= rnd[1:0];
                wait_q  <= 2'd0;
                rdata_q <= mem_q[idx];
            end else if (mem_req_i.req) begin
                wait_q <= wait_q + 2'd1;
            end
        end
    end

    // byte-enabled write
    always @(posedge clk_i) begin
        if (gnt && mem_req_i.we) begin
            for (k = 0; k < 8; k++) begin
                if (mem_req_i.be[k]) begin
                    mem_q[idx][8*k +: 8] <= mem_req_i.wdata[8*k +: 8];
                end
            end
        end
    end

endmodule

// File: verification/tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu
    import lsu_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  lsu_valid_i;
    logic                  fu_store_i;
    lsu_op_e               operator_i;
    logic [`LSU_XLEN-1:0]  operand_a_i;
    logic [`LSU_XLEN-1:0]  operand_b_i;
    logic [`LSU_XLEN-1:0]  imm_i;
    logic [`LSU_TID_W-1:0] trans_id_i;
    logic                  lsu_ready_o;
    mem_req_t              mem_req;
    mem_rsp_t              mem_rsp;
    logic                  lsu_valid_o;
    logic [`LSU_TID_W-1:0] lsu_trans_id_o;
    logic [`LSU_XLEN-1:0]  lsu_result_o;
    lsu_ex_t               lsu_ex_o;

    // reference copy of the data memory
    logic [63:0] ref_mem [0:63];
    logic [2:0]  next_tid;
    logic [2:0]  exp_tid_q [$];
    logic [63:0] exp_res_q [$];
    logic        req_seen;
    integer      seed;
    integer      cycles = 0;

    lsu_top i_dut (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .lsu_valid_i    ( lsu_valid_i    ),
        .fu_store_i     ( fu_store_i     ),
        .operator_i     ( operator_i     ),
        .operand_a_i    ( operand_a_i    ),
        .operand_b_i    ( operand_b_i    ),
        .imm_i          ( imm_i          ),
        .trans_id_i     ( trans_id_i     ),
        .lsu_ready_o    ( lsu_ready_o    ),
        .mem_req_o      ( mem_req        ),
        .mem_rsp_i      ( mem_rsp        ),
        .lsu_valid_o    ( lsu_valid_o    ),
        .lsu_trans_id_o ( lsu_trans_id_o ),
        .lsu_result_o   ( lsu_result_o   ),
        .lsu_ex_o       ( lsu_ex_o       )
    );

    tb_lsu_mem i_mem (
        .clk_i     ( clk_i   ),
        .rst_ni    ( rst_ni  ),
        .mem_req_i ( mem_req ),
        .mem_rsp_o ( mem_rsp )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    // any memory request at all, for the fault tests
    always @(negedge clk_i) begin
        if (mem_req.req) begin
            req_seen = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // reference model helpers
    // ------------------------------------------------------------
    function automatic int size_bytes(input lsu_op_e op);
        case (op)
            LD, SD:      return 8;
            LW, LWU, SW: return 4;
            LH, LHU, SH: return 2;
            default:     return 1;
        endcase
    endfunction

    function automatic logic is_store(input lsu_op_e op);
        return (op == SD) || (op == SW) || (op == SH) || (op == SB);
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // selected bytes, then sign fill for LB, LH and LW
    function automatic logic [63:0] expect_load(input lsu_op_e op, input logic [63:0] addr);
        logic [63:0] word;
        logic [63:0] val;
        int          nbytes;
        int          off;
        int          k;
        word   = ref_mem[addr[8:3]];
        nbytes = size_bytes(op);
        off    = addr[2:0];
        val    = 64'h0;
        for (k = 0; k < nbytes; k++) begin
            val[8*k +: 8] = word[8*(off+k) +: 8];
        end
        if ((op == LB || op == LH || op == LW) && val[8*nbytes-1]) begin
            for (k = nbytes; k < 8; k++) begin
                val[8*k +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    function automatic void model_store(input lsu_op_e op, input logic [63:0] addr,
                                        input logic [63:0] data);
        int nbytes;
        int off;
        int k;
        nbytes = size_bytes(op);
        off    = addr[2:0];
        for (k = 0; k < nbytes; k++) begin
            ref_mem[addr[8:3]][8*(off+k) +: 8] = data[8*k +: 8];
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp_val);
        if (got !== exp_val) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp_val);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // issue and result handling
    // ------------------------------------------------------------
    task automatic issue_op(input lsu_op_e op, input logic [63:0] a, input logic [63:0] b,
                            input logic [63:0] imm, output logic [2:0] tid);
        tid = next_tid;
        next_tid = next_tid + 3'd1;
        @(posedge clk_i);
        lsu_valid_i <= 1'b1;
        fu_store_i  <= is_store(op);
        operator_i  <= op;
        operand_a_i <= a;
        operand_b_i <= b;
        imm_i       <= imm;
        trans_id_i  <= tid;
        @(negedge clk_i);
        while (!lsu_ready_o) @(negedge clk_i);
        // accepted on this edge
        @(posedge clk_i);
        lsu_valid_i <= 1'b0;
    endtask

    task automatic wait_valid();
        @(negedge clk_i);
        while (!lsu_valid_o) @(negedge clk_i);
    endtask

    task automatic check_result(input logic [2:0] tid, input logic [63:0] res,
                                input logic exv, input lsu_cause_e cause,
                                input logic [63:0] tval);
        check_value("lsu_trans_id_o", lsu_trans_id_o, tid);
        check_value("lsu_result_o", lsu_result_o, res);
        check_value("lsu_ex_o.valid", lsu_ex_o.valid, exv);
        if (exv) begin
            check_value("lsu_ex_o.cause", lsu_ex_o.cause, cause);
            check_value("lsu_ex_o.tval", lsu_ex_o.tval, tval);
        end
    endtask

    task automatic do_load(input lsu_op_e op, input logic [63:0] a, input logic [63:0] imm);
        logic [2:0]  tid;
        logic [63:0] exp_val;
        exp_val = expect_load(op, a + imm);
        issue_op(op, a, 64'h0, imm, tid);
        wait_valid();
        check_result(tid, exp_val, 1'b0, LD_ADDR_MISALIGNED, 64'h0);
    endtask

    task automatic do_store(input lsu_op_e op, input logic [63:0] a, input logic [63:0] imm,
                            input logic [63:0] b, input logic check_port);
        logic [2:0]  tid;
        logic [63:0] addr;
        logic [15:0] mask;
        logic [63:0] lanes;
        logic [63:0] lane_mask;
        int          nbytes;
        int          off;
        int          k;
        addr      = a + imm;
        nbytes    = size_bytes(op);
        off       = addr[2:0];
        mask      = ((16'd1 << nbytes) - 16'd1) << off;
        lanes     = 64'h0;
        lane_mask = 64'h0;
        for (k = 0; k < nbytes; k++) begin
            lanes[8*(off+k) +: 8]     = b[8*k +: 8];
            lane_mask[8*(off+k) +: 8] = 8'hff;
        end
        issue_op(op, a, b, imm, tid);
        if (check_port) begin
            @(negedge clk_i);
            while (!mem_req.req) @(negedge clk_i);
            check_value("mem_req_o.we", mem_req.we, 1'b1);
            check_value("mem_req_o.addr", mem_req.addr, addr);
            check_value("mem_req_o.be", mem_req.be, mask[7:0]);
            check_value("mem_req_o.wdata", mem_req.wdata & lane_mask, lanes);
        end
        model_store(op, addr, b);
        wait_valid();
        check_result(tid, 64'h0, 1'b0, ST_ADDR_MISALIGNED, 64'h0);
    endtask

    task automatic expect_fault(input lsu_op_e op, input logic [63:0] a,
                                input logic [63:0] imm, input lsu_cause_e cause);
        logic [2:0] tid;
        req_seen = 1'b0;
        issue_op(op, a, 64'h5555_aaaa_5555_aaaa, imm, tid);
        wait_valid();
        check_result(tid, 64'h0, 1'b1, cause, a + imm);
        check_value("mem_req_o.req seen", req_seen | mem_req.req, 1'b0);
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_load_extend();
        int off;
        do_store(SD, 64'h60, 64'h20, 64'h700d_8e71_25c3_3c81, 1'b0);
        for (off = 0; off < 8; off++) begin
            do_load(LB, 64'h80, 64'(off));
            do_load(LBU, 64'h80, 64'(off));
            if (off % 2 == 0) begin
                do_load(LH, 64'h80, 64'(off));
                do_load(LHU, 64'h80, 64'(off));
            end
            if (off % 4 == 0) begin
                do_load(LW, 64'h80, 64'(off));
                do_load(LWU, 64'h80, 64'(off));
            end
        end
        do_load(LD, 64'h80, 64'h0);
    endtask

    task automatic store_then_reload(input lsu_op_e op, input int off);
        do_store(op, 64'h100, 64'(off), rand64(), 1'b1);
        do_load(LD, 64'h100, 64'h0);
    endtask

    task automatic test_store_lanes();
        int off;
        do_store(SD, 64'h100, 64'h0, rand64(), 1'b0);
        for (off = 0; off < 8; off++) begin
            store_then_reload(SB, off);
            if (off % 2 == 0) begin
                store_then_reload(SH, off);
            end
            if (off % 4 == 0) begin
                store_then_reload(SW, off);
            end
        end
    endtask

    task automatic test_misaligned();
        expect_fault(LH, 64'h200, 64'h1, LD_ADDR_MISALIGNED);
        expect_fault(LW, 64'h200, 64'h2, LD_ADDR_MISALIGNED);
        expect_fault(LD, 64'h200, 64'h4, LD_ADDR_MISALIGNED);
        expect_fault(SH, 64'h200, 64'h3, ST_ADDR_MISALIGNED);
        expect_fault(SW, 64'h200, 64'h1, ST_ADDR_MISALIGNED);
        expect_fault(SD, 64'h200, 64'h6, ST_ADDR_MISALIGNED);
    endtask

    task automatic test_page_fault();
        // adder carries into bit 38
        expect_fault(LD, 64'h0000_003f_ffff_fff8, 64'h8, LOAD_PAGE_FAULT);
        expect_fault(SD, 64'h8000_0000_0000_0000, 64'h0, STORE_PAGE_FAULT);
        // also misaligned, page fault takes priority
        expect_fault(LW, 64'h0000_0080_0000_0000, 64'h1, LOAD_PAGE_FAULT);
        expect_fault(SH, 64'hffff_ff00_0000_0000, 64'h3, STORE_PAGE_FAULT);
    endtask

    task automatic issue_stream();
        lsu_op_e     ops [11] = '{LD, LW, LWU, LH, LHU, LB, LBU, SD, SW, SH, SB};
        lsu_op_e     op;
        logic [31:0] r;
        logic [63:0] imm;
        logic [63:0] b;
        logic [63:0] res;
        logic [2:0]  tid;
        int          n;
        int          dw;
        int          off;
        for (n = 0; n < 20; n++) begin
            r   = $random(seed);
            op  = ops[r[7:0] % 11];
            dw  = r[12:11];
            off = r[10:8] & ~(size_bytes(op) - 1);
            imm = 64'(8 * dw + off);
            b   = rand64();
            if (is_store(op)) begin
                model_store(op, 64'h40 + imm, b);
                res = 64'h0;
            end else begin
                res = expect_load(op, 64'h40 + imm);
            end
            issue_op(op, 64'h40, b, imm, tid);
            exp_tid_q.push_back(tid);
            exp_res_q.push_back(res);
        end
    endtask

    task automatic collect_stream();
        int n;
        for (n = 0; n < 20; n++) begin
            wait_valid();
            if (exp_tid_q.size() == 0) begin
                $display("result arrived with no operation outstanding");
                $display("SIMULATION FAILED");
                $fatal(1, "unexpected result");
            end
            check_result(exp_tid_q.pop_front(), exp_res_q.pop_front(), 1'b0,
                         LD_ADDR_MISALIGNED, 64'h0);
        end
    endtask

    task automatic test_random_stream();
        int n;
        for (n = 0; n < 4; n++) begin
            do_store(SD, 64'h40, 64'(8 * n), rand64(), 1'b0);
        end
        fork
            issue_stream();
            collect_stream();
        join
    endtask

    initial begin
        seed        = 32'h5b3d_b403;
        next_tid    = 3'd0;
        req_seen    = 1'b0;
        rst_ni      = 1'b0;
        lsu_valid_i = 1'b0;
        fu_store_i  = 1'b0;
        operator_i  = LD;
        operand_a_i = 64'h0;
        operand_b_i = 64'h0;
        imm_i       = 64'h0;
        trans_id_i  = 3'd0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("lsu_ready_o", lsu_ready_o, 1'b1);
        check_value("lsu_valid_o", lsu_valid_o, 1'b0);
        check_value("mem_req_o.req", mem_req.req, 1'b0);

        test_load_extend();
        test_store_lanes();
        test_misaligned();
        test_page_fault();
        test_random_stream();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+src
src/lsu_pkg.sv
src/lsu_addr_gen.sv
src/lsu_load_align.sv
src/lsu_issue_buffer.sv
src/lsu_mem_ctrl.sv
src/lsu_top.sv
verification/tb_lsu_mem.sv
verification/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/lsu_addr_gen.sv
      - src/lsu_load_align.sv
      - src/lsu_issue_buffer.sv
      - src/lsu_mem_ctrl.sv
      - src/lsu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_lsu_mem.sv
      - verification/tb_lsu.sv
